/* source/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // Architectural register file size, x0 included
    localparam int ARCH_REGS = 32;

    // Physical register index width, enough for 64 registers
    localparam int PHYS_REG_W = 6;

    // Reorder buffer id width, enough for 8 entries
    localparam int ROB_ID_W = 3;

    // Architectural register index
    typedef logic [4:0] arch_reg_t;

    // Physical register index
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

    // Reorder buffer entry id
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // Controller states
    // ST_REBUILD scans the physical registers into the free list
    // ST_RUN accepts dispatches
    typedef enum logic {
        ST_REBUILD,
        ST_RUN
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/rename_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// Rename allocation for one dispatched instruction
interface alloc_if;
    import rename_pkg::*;

    logic      fire;
    arch_reg_t rd;
    phys_reg_t new_prd;
    phys_reg_t old_prd;
    logic      has_rd;

    // Dispatch acceptance and destination qualification
    modport ctrl (output fire, output rd, output has_rd);
    // Alias table reads old mapping, writes new one
    modport map (input fire, input rd, input has_rd, input new_prd, output old_prd);
    // Free list head supplies the new register
    modport freelist (input fire, input has_rd, output new_prd);
    // Reorder buffer records the whole allocation
    modport rob (input fire, input rd, input has_rd, input new_prd, input old_prd);
endinterface

// Retirement of the reorder buffer head
interface commit_if;
    import rename_pkg::*;

    logic      valid;
    arch_reg_t rd;
    phys_reg_t prd;
    phys_reg_t old_prd;
    logic      has_rd;

    modport rob (output valid, output rd, output prd, output old_prd, output has_rd);
    modport map (input valid, input rd, input prd, input old_prd, input has_rd);
    // Free list only recycles the old mapping
    modport freelist (input valid, input has_rd, input old_prd);
endinterface

`default_nettype wire

/* source/rename_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_reg_t dispatch_rd,
    input  logic                  dispatch_has_rd,
    input  logic                  rob_full,
    input  logic                  fl_empty,
    input  logic                  scan_last,
    output logic                  dispatch_ready,
    output logic                  scan_start,
    output logic                  rebuild_push,
    output logic                  restore,
    alloc_if.ctrl                 alloc
);
    import rename_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        rst_q;
    logic        kick_q;
    logic        has_rd;

    // Rebuild kick one cycle after the reset release or a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            rst_q  <= 1'b1;
            kick_q <= 1'b0;
        end else begin
            rst_q  <= 1'b0;
            kick_q <= flush || rst_q;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_REBUILD: if (scan_last) state_next = ST_RUN;
            ST_RUN:     state_next = ST_RUN;
            default:    state_next = ST_REBUILD;
        endcase
        // Flush always wins, even on the last scan index
        if (flush) state_next = ST_REBUILD;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_REBUILD;
        end else begin
            state <= state_next;
        end
    end

    // x0 is never renamed
    assign has_rd = dispatch_has_rd && (dispatch_rd != '0);

    // Free list only matters when a register is needed
    assign dispatch_ready = (state == ST_RUN) && !rob_full && !(fl_empty && has_rd);

    assign alloc.fire   = dispatch_valid && dispatch_ready;
    assign alloc.rd     = dispatch_rd;
    assign alloc.has_rd = has_rd;

    assign scan_start   = kick_q;
    assign restore      = kick_q;
    assign rebuild_push = (state == ST_REBUILD);
endmodule

`default_nettype wire

/* source/scan_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_counter #(
    parameter int PR_ENTRIES = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scan_start,
    output rename_pkg::phys_reg_t scan_idx,
    output logic                  scan_valid,
    output logic                  scan_last
);
    import rename_pkg::*;

    localparam phys_reg_t LAST_IDX = phys_reg_t'(PR_ENTRIES - 1);

    phys_reg_t cnt;
    logic      active;

    // Index 0 is presented in the start cycle itself
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (scan_start) begin
            cnt    <= phys_reg_t'(1);
            active <= 1'b1;
        end else if (active) begin
            if (cnt == LAST_IDX) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign scan_valid = scan_start || active;
    assign scan_idx   = scan_start ? '0 : cnt;
    assign scan_last  = scan_valid && (scan_idx == LAST_IDX);
endmodule

`default_nettype wire

/* source/map_table.sv */
`timescale 1ns/100ps
`default_nettype none

module map_table #(
    parameter int PR_ENTRIES = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  restore,
    input  rename_pkg::arch_reg_t dispatch_rs1,
    input  rename_pkg::arch_reg_t dispatch_rs2,
    output rename_pkg::phys_reg_t dispatch_prs1,
    output rename_pkg::phys_reg_t dispatch_prs2,
    input  rename_pkg::phys_reg_t scan_idx,
    output logic                  in_use,
    alloc_if.map                  alloc,
    commit_if.map                 commit
);
    import rename_pkg::*;

    phys_reg_t             spec_rat    [ARCH_REGS];
    phys_reg_t             retired_rat [ARCH_REGS];
    logic [PR_ENTRIES-1:0] in_use_map;
    logic                  retire;

    // Only real destinations touch the retired state
    assign retire = commit.valid && commit.has_rd;

    // Source lookups and old mapping of rd
    assign dispatch_prs1 = spec_rat[dispatch_rs1];
    assign dispatch_prs2 = spec_rat[dispatch_rs2];
    assign alloc.old_prd = spec_rat[alloc.rd];

    // Probed by the free list rebuild
    assign in_use = in_use_map[scan_idx];

    // Speculative table
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_rat[i] <= phys_reg_t'(i);
            end
        end else if (restore) begin
            spec_rat <= retired_rat;
        end else if (alloc.fire && alloc.has_rd) begin
            spec_rat[alloc.rd] <= alloc.new_prd;
        end
    end

    // Retired table, identity out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                retired_rat[i] <= phys_reg_t'(i);
            end
        end else if (retire) begin
            retired_rat[commit.rd] <= commit.prd;
        end
    end

    // Registers held by the retired table
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PR_ENTRIES; i++) begin
                in_use_map[i] <= (i < ARCH_REGS);
            end
        end else if (retire) begin
            // prd and old_prd always differ
            in_use_map[commit.old_prd] <= 1'b0;
            in_use_map[commit.prd]     <= 1'b1;
        end
    end
endmodule

`default_nettype wire

/* source/free_list.sv */
`timescale 1ns/100ps
`default_nettype none

module free_list #(
    parameter int PR_ENTRIES = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  restore,
    input  logic                  rebuild_push,
    input  logic                  in_use,
    input  rename_pkg::phys_reg_t scan_idx,
    output logic                  empty,
    alloc_if.freelist             alloc,
    commit_if.freelist            commit
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(PR_ENTRIES);
    localparam int CNT_W = $clog2(PR_ENTRIES + 1);

    phys_reg_t        fifo_mem [PR_ENTRIES];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] head_base;
    logic [PTR_W-1:0] tail_base;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_base;
    logic             push_scan;
    logic             push_commit;
    logic             push;
    logic             pop;
    phys_reg_t        push_data;

    // Entry count need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(PR_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Rebuild and commit pushes never overlap
    assign push_scan   = rebuild_push && !in_use;
    assign push_commit = commit.valid && commit.has_rd;
    assign push        = push_scan || push_commit;
    assign push_data   = push_scan ? scan_idx : commit.old_prd;
    assign pop         = alloc.fire && alloc.has_rd;

    // Restore empties the queue, first scan push lands in the same cycle
    assign head_base  = restore ? '0 : head;
    assign tail_base  = restore ? '0 : tail;
    assign count_base = restore ? '0 : count;

    assign alloc.new_prd = fifo_mem[head];
    assign empty         = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= pop ? ptr_inc(head_base) : head_base;
            tail  <= push ? ptr_inc(tail_base) : tail_base;
            count <= count_base + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[tail_base] <= push_data;
        end
    end
endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                restore,
    input  logic                flush,
    input  logic                complete_valid,
    input  rename_pkg::rob_id_t complete_rob_id,
    output rename_pkg::rob_id_t alloc_id,
    output logic                full,
    alloc_if.rob                alloc,
    commit_if.rob               commit
);
    import rename_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // Entry payload
    arch_reg_t        rd_q      [ROB_DEPTH];
    phys_reg_t        prd_q     [ROB_DEPTH];
    phys_reg_t        old_prd_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] has_rd_q;
    // Entry status
    logic [ROB_DEPTH-1:0] done_q;
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             commit_fire;

    // Head retires once done, never in a flush cycle
    assign commit_fire = (count != '0) && done_q[head] && !flush;

    assign commit.valid   = commit_fire;
    assign commit.rd      = rd_q[head];
    assign commit.prd     = prd_q[head];
    assign commit.old_prd = old_prd_q[head];
    assign commit.has_rd  = has_rd_q[head];

    assign alloc_id = rob_id_t'(tail);
    assign full     = (count == CNT_W'(ROB_DEPTH));

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush || restore) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (complete_valid) begin
                done_q[complete_rob_id[IDX_W-1:0]] <= 1'b1;
            end
            // A fresh entry starts not done
            if (alloc.fire) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc.fire) - CNT_W'(commit_fire);
        end
    end

    // Payload as presented, has_rd qualifies it at commit
    always_ff @(posedge clk) begin
        if (alloc.fire) begin
            rd_q[tail]      <= alloc.rd;
            prd_q[tail]     <= alloc.new_prd;
            old_prd_q[tail] <= alloc.old_prd;
            has_rd_q[tail]  <= alloc.has_rd;
        end
    end
endmodule

`default_nettype wire

/* source/rename_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_unit #(
    parameter int PR_ENTRIES = 64,
    parameter int ROB_DEPTH  = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  logic                  dispatch_has_rd,
    input  logic                  complete_valid,
    input  rename_pkg::arch_reg_t dispatch_rd,
    input  rename_pkg::arch_reg_t dispatch_rs1,
    input  rename_pkg::arch_reg_t dispatch_rs2,
    input  rename_pkg::rob_id_t   complete_rob_id,
    output logic                  dispatch_ready,
    output logic                  commit_valid,
    output rename_pkg::phys_reg_t dispatch_prs1,
    output rename_pkg::phys_reg_t dispatch_prs2,
    output rename_pkg::phys_reg_t dispatch_prd,
    output rename_pkg::phys_reg_t commit_prd,
    output rename_pkg::phys_reg_t commit_freed_prd,
    output rename_pkg::rob_id_t   dispatch_rob_id,
    output rename_pkg::arch_reg_t commit_rd
);
    import rename_pkg::*;

    alloc_if  alloc ();
    commit_if commit ();

    // Rebuild and status wiring
    logic      rob_full;
    logic      fl_empty;
    logic      scan_start;
    logic      scan_last;
    logic      rebuild_push;
    logic      restore;
    logic      in_use;
    phys_reg_t scan_idx;

    rename_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .dispatch_valid  (dispatch_valid),
        .dispatch_rd     (dispatch_rd),
        .dispatch_has_rd (dispatch_has_rd),
        .rob_full        (rob_full),
        .fl_empty        (fl_empty),
        .scan_last       (scan_last),
        .dispatch_ready  (dispatch_ready),
        .scan_start      (scan_start),
        .rebuild_push    (rebuild_push),
        .restore         (restore),
        .alloc           (alloc)
    );

    // scan_valid stays internal, rebuild state already covers it
    scan_counter #(.PR_ENTRIES(PR_ENTRIES)) u_scan (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .scan_idx   (scan_idx),
        .scan_valid (),
        .scan_last  (scan_last)
    );

    map_table #(.PR_ENTRIES(PR_ENTRIES)) u_map (
        .clk           (clk),
        .rst           (rst),
        .restore       (restore),
        .dispatch_rs1  (dispatch_rs1),
        .dispatch_rs2  (dispatch_rs2),
        .dispatch_prs1 (dispatch_prs1),
        .dispatch_prs2 (dispatch_prs2),
        .scan_idx      (scan_idx),
        .in_use        (in_use),
        .alloc         (alloc),
        .commit        (commit)
    );

    free_list #(.PR_ENTRIES(PR_ENTRIES)) u_free (
        .clk          (clk),
        .rst          (rst),
        .restore      (restore),
        .rebuild_push (rebuild_push),
        .in_use       (in_use),
        .scan_idx     (scan_idx),
        .empty        (fl_empty),
        .alloc        (alloc),
        .commit       (commit)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk             (clk),
        .rst             (rst),
        .restore         (restore),
        .flush           (flush),
        .complete_valid  (complete_valid),
        .complete_rob_id (complete_rob_id),
        .alloc_id        (dispatch_rob_id),
        .full            (rob_full),
        .alloc           (alloc),
        .commit          (commit)
    );

    // No destination reports prd 0
    assign dispatch_prd = alloc.has_rd ? alloc.new_prd : '0;

    assign commit_valid     = commit.valid;
    assign commit_rd        = commit.rd;
    assign commit_prd       = commit.prd;
    assign commit_freed_prd = commit.old_prd;
endmodule

`default_nettype wire

/* verification/rename_props.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  flush,
    input logic                  dispatch_valid,
    input logic                  dispatch_ready,
    input logic                  dispatch_has_rd,
    input rename_pkg::arch_reg_t dispatch_rd,
    input rename_pkg::phys_reg_t dispatch_prd,
    input logic                  commit_valid,
    input rename_pkg::phys_reg_t commit_prd,
    input rename_pkg::phys_reg_t commit_freed_prd
);
    // Rebuild starts right after a flush
    a_ready_after_flush: assert property (
        @(posedge clk) disable iff (rst) flush |=> !dispatch_ready
    ) else $error("dispatch_ready high in the cycle after flush");

    // A retiring mapping never frees itself
    a_commit_distinct: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> (commit_freed_prd != commit_prd)
    ) else $error("commit frees the register it retires");

    // Real destinations always get a register other than 0
    a_dispatch_prd: assert property (
        @(posedge clk) disable iff (rst)
        (dispatch_valid && dispatch_ready && dispatch_has_rd && (dispatch_rd != '0))
        |-> (dispatch_prd != '0)
    ) else $error("accepted dispatch with a destination reports prd 0");
endmodule

bind rename_unit rename_props u_props (
    .clk              (clk),
    .rst              (rst),
    .flush            (flush),
    .dispatch_valid   (dispatch_valid),
    .dispatch_ready   (dispatch_ready),
    .dispatch_has_rd  (dispatch_has_rd),
    .dispatch_rd      (dispatch_rd),
    .dispatch_prd     (dispatch_prd),
    .commit_valid     (commit_valid),
    .commit_prd       (commit_prd),
    .commit_freed_prd (commit_freed_prd)
);

`default_nettype wire

/* verification/tb_rename_unit.sv */
`timescale 1ns/100ps
`default_nettype none

// Free-running testbench clock
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end
endmodule

module tb_rename_unit;
    import rename_pkg::*;

    // Small register file keeps the free list short
    localparam int PR_ENTRIES  = 36;
    localparam int ROB_DEPTH   = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int TIMEOUT     = 4 * PR_ENTRIES;
    // Nine hex fields per vector line
    localparam int VEC_FIELDS  = 9;
    localparam int VEC_LINES   = 64;

    logic      clk;
    logic      rst;
    logic      flush;
    logic      dispatch_valid;
    logic      dispatch_has_rd;
    logic      complete_valid;
    arch_reg_t dispatch_rd;
    arch_reg_t dispatch_rs1;
    arch_reg_t dispatch_rs2;
    rob_id_t   complete_rob_id;
    logic      dispatch_ready;
    logic      commit_valid;
    phys_reg_t dispatch_prs1;
    phys_reg_t dispatch_prs2;
    phys_reg_t dispatch_prd;
    phys_reg_t commit_prd;
    phys_reg_t commit_freed_prd;
    rob_id_t   dispatch_rob_id;
    arch_reg_t commit_rd;

    logic [7:0]  vec_mem [VEC_FIELDS*VEC_LINES];
    // Observed commits as {rd, prd, freed prd}
    logic [16:0] commit_q [$];
    logic [31:0] lfsr_state;

    tb_clock_gen #(.PERIOD(100)) u_clk (.clk(clk));

    rename_unit #(.PR_ENTRIES(PR_ENTRIES), .ROB_DEPTH(ROB_DEPTH)) DUT (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .dispatch_valid   (dispatch_valid),
        .dispatch_has_rd  (dispatch_has_rd),
        .complete_valid   (complete_valid),
        .dispatch_rd      (dispatch_rd),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_rs2     (dispatch_rs2),
        .complete_rob_id  (complete_rob_id),
        .dispatch_ready   (dispatch_ready),
        .commit_valid     (commit_valid),
        .dispatch_prs1    (dispatch_prs1),
        .dispatch_prs2    (dispatch_prs2),
        .dispatch_prd     (dispatch_prd),
        .commit_prd       (commit_prd),
        .commit_freed_prd (commit_freed_prd),
        .dispatch_rob_id  (dispatch_rob_id),
        .commit_rd        (commit_rd)
    );

    // Commit is stable mid-cycle and retires at the next rising edge
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            commit_q.push_back({commit_rd, commit_prd, commit_freed_prd});
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Present the instruction, hold it until accepted
    task automatic dispatch_instr(input string tag, input int base);
        int waited;
        waited          = 0;
        dispatch_rd     = vec_mem[base+1][4:0];
        dispatch_rs1    = vec_mem[base+2][4:0];
        dispatch_rs2    = vec_mem[base+3][4:0];
        dispatch_has_rd = vec_mem[base+4][0];
        dispatch_valid  = 1'b1;
        @(negedge clk);
        while (!dispatch_ready) begin
            if (waited == TIMEOUT) begin
                $display("Timeout waiting for dispatch_ready at %s", tag);
                abort_run();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        check_value({tag, " prs1"}, 32'(vec_mem[base+5]), 32'(dispatch_prs1));
        check_value({tag, " prs2"}, 32'(vec_mem[base+6]), 32'(dispatch_prs2));
        check_value({tag, " prd"}, 32'(vec_mem[base+7]), 32'(dispatch_prd));
        check_value({tag, " rob_id"}, 32'(vec_mem[base+8]), 32'(dispatch_rob_id));
        next_cycle();
        dispatch_valid  = 1'b0;
        dispatch_has_rd = 1'b0;
        dispatch_rd     = '0;
        dispatch_rs1    = '0;
        dispatch_rs2    = '0;
    endtask

    task automatic complete_entry(input int base);
        complete_valid  = 1'b1;
        complete_rob_id = vec_mem[base+1][2:0];
        next_cycle();
        complete_valid  = 1'b0;
        complete_rob_id = '0;
    endtask

    // Oldest observed commit against the expected one
    task automatic expect_commit(input string tag, input int base);
        int          waited;
        logic [16:0] seen;
        waited = 0;
        while (commit_q.size() == 0) begin
            if (waited == TIMEOUT) begin
                $display("Timeout waiting for a commit at %s", tag);
                abort_run();
            end else begin
                waited++;
                next_cycle();
            end
        end
        seen = commit_q.pop_front();
        check_value({tag, " rd"}, 32'(vec_mem[base+1]), 32'(seen[16:12]));
        // No destination, nothing renamed to compare
        if (vec_mem[base+4] != 8'h00) begin
            check_value({tag, " prd"}, 32'(vec_mem[base+2]), 32'(seen[11:6]));
            check_value({tag, " freed prd"}, 32'(vec_mem[base+3]), 32'(seen[5:0]));
        end
    endtask

    // Rebuild must hold ready low for one cycle per physical register
    task automatic wait_rebuild(input string tag);
        int low_cycles;
        low_cycles = 0;
        @(negedge clk);
        while (!dispatch_ready) begin
            if (low_cycles == TIMEOUT) begin
                $display("Timeout waiting for the rebuild to end at %s", tag);
                abort_run();
            end else begin
                low_cycles++;
                @(negedge clk);
            end
        end
        check_value({tag, " rebuild cycles"}, PR_ENTRIES, low_cycles);
        next_cycle();
    endtask

    task automatic flush_and_rebuild(input string tag);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        wait_rebuild(tag);
    endtask

    task automatic sample_ready(input string tag, input int base);
        @(negedge clk);
        check_value({tag, " ready"}, 32'(vec_mem[base+1][0]), 32'(dispatch_ready));
        next_cycle();
    endtask

    task automatic run_command(input int index, input int base);
        string tag;
        tag = $sformatf("cmd %0d", index);
        case (vec_mem[base])
            8'h01: dispatch_instr(tag, base);
            8'h02: complete_entry(base);
            8'h03: expect_commit(tag, base);
            8'h04: flush_and_rebuild(tag);
            8'h05: repeat (vec_mem[base+1]) next_cycle();
            8'h06: sample_ready(tag, base);
            default: begin
                $display("Unknown vector command %h at %s", vec_mem[base], tag);
                abort_run();
            end
        endcase
    endtask

    initial begin
        int   base;
        int   index;
        int   gap;
        logic finished;
        rst             = 1'b1;
        flush           = 1'b0;
        dispatch_valid  = 1'b0;
        dispatch_has_rd = 1'b0;
        complete_valid  = 1'b0;
        dispatch_rd     = '0;
        dispatch_rs1    = '0;
        dispatch_rs2    = '0;
        complete_rob_id = '0;
        lfsr_state      = 32'hb8f8;
        base            = 0;
        index           = 0;
        finished        = 1'b0;
        $readmemh("verification/rename_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Rebuild runs in the cycles after the reset release
        next_cycle();
        wait_rebuild("reset release");
        while (!finished) begin
            if (index == VEC_LINES || $isunknown(vec_mem[base])) begin
                $display("Vector file has no end marker after %0d commands", index);
                abort_run();
            end else if (vec_mem[base] == 8'hff) begin
                finished = 1'b1;
            end else begin
                // 0 to 3 idle cycles before each command
                random_bits(2, gap);
                repeat (gap) next_cycle();
                run_command(index, base);
                index++;
                base += VEC_FIELDS;
            end
        end
        // Room for a stray commit to show up
        repeat (4) next_cycle();
        if (commit_q.size() != 0) begin
            $display("%0d commits happened that no vector expected", commit_q.size());
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end
endmodule

`default_nettype wire

/* verification/rename_vectors.txt */
// One command per line, nine hex fields: op then eight arguments
// 01 dispatch: rd rs1 rs2 has_rd exp_prs1 exp_prs2 exp_prd exp_rob_id
// 02 complete: rob_id / 03 commit: rd prd freed_prd check_prd / 04 flush
// 05 idle: cycles / 06 ready: expected level / ff end
// Identity mappings, then a renamed source
01 01 02 03 01 02 03 20 00
01 02 01 00 01 20 00 21 01
// x0 and a missing destination take no register
01 00 02 04 01 21 04 00 02
01 05 05 01 00 05 20 00 03
// Four entries outstanding
06 00 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00
03 01 20 01 01 00 00 00 00
06 01 00 00 00 00 00 00 00
01 03 01 03 01 20 03 22 00
// Out of order completion, in-order commit
02 03 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00
02 02 00 00 00 00 00 00 00
02 01 00 00 00 00 00 00 00
03 02 21 02 01 00 00 00 00
03 00 00 00 00 00 00 00 00
03 05 00 00 00 00 00 00 00
03 03 22 03 01 00 00 00 00
// Last initial register, then the freed ones
01 04 03 02 01 22 21 23 01
01 06 04 00 01 23 00 01 02
01 07 06 07 01 01 07 02 03
02 02 00 00 00 00 00 00 00
04 00 00 00 00 00 00 00 00
// Retired mappings, free registers in ascending order
01 01 01 04 01 20 04 01 00
01 08 03 06 01 22 06 02 01
01 09 01 00 01 01 00 03 02
01 0a 02 07 01 21 07 23 03
02 01 00 00 00 00 00 00 00
02 03 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00
02 02 00 00 00 00 00 00 00
03 01 01 20 01 00 00 00 00
03 08 02 08 01 00 00 00 00
03 09 03 09 01 00 00 00 00
03 0a 23 0a 01 00 00 00 00
01 0b 01 0b 01 01 0b 20 00
05 03 00 00 00 00 00 00 00
ff 00 00 00 00 00 00 00 00

/* project.f */
source/rename_pkg.sv
source/rename_ifs.sv
source/rename_ctrl.sv
source/scan_counter.sv
source/map_table.sv
source/free_list.sv
source/reorder_buffer.sv
source/rename_unit.sv
verification/rename_props.sv
verification/tb_rename_unit.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rename_unit
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
